//--- dac_channel.f
+incdir+.
dac_channel_pkg.sv
dac_channel_regs.sv
dac_sample_source.sv
dac_gain_offset.sv
dac_fir_filter.sv
dac_stat_monitor.sv
dac_channel_top.sv
tb_dac_channel.sv

//--- dac_channel_defines.svh
`ifndef DAC_CHANNEL_DEFINES_SVH
`define DAC_CHANNEL_DEFINES_SVH

// Register map. Byte addresses, word aligned, decoded on paddr[11:2].
`define DAC_REG_GAIN        12'h000
`define DAC_REG_OFFSET      12'h004
`define DAC_REG_FILTER_COEF 12'h008
`define DAC_REG_MUX         12'h00C
`define DAC_REG_RAW         12'h010
`define DAC_REG_STAT_CFG    12'h014
`define DAC_REG_STAT_MIN    12'h018
`define DAC_REG_STAT_MAX    12'h01C
`define DAC_REG_STAT_LIMIT  12'h020
`define DAC_REG_STAT_COUNT  12'h024
`define DAC_REG_ATT         12'h028
`define DAC_REG_AMP_EN      12'h02C
`define DAC_REG_LED         12'h030

// Data path widths.
`define DAC_SAMPLE_W        16
`define DAC_TAPS            4

// Fixed point formats: gain is Q4.12, FIR coefficients are Q1.14.
`define DAC_GAIN_FRAC       12
`define DAC_COEF_FRAC       14

// Reset values.
`define DAC_RESET_ATT       2'b11
`define DAC_UNITY_COEF      16'sd16384

`endif

//--- dac_channel_pkg.sv
package dac_channel_pkg;

    // Sample source select. Unlisted codes give zero-valued samples.
    typedef enum logic [2:0] {
        MUX_RAW    = 3'd0,
        MUX_STREAM = 3'd1,
        MUX_RAMP   = 3'd2
    } sample_mux_e;

    // Four-phase req/ack capture.
    typedef enum logic [1:0] {
        SRC_IDLE     = 2'd0,
        SRC_ACK      = 2'd1,
        SRC_WAIT_LOW = 2'd2
    } src_state_e;

    typedef struct packed {
        logic [15:0]        gain;
        logic signed [15:0] offset;
        sample_mux_e        mux;
        logic [31:0]        raw;
        logic [1:0]         att;
        logic               stat_en;
        logic               stat_clear;
        logic [31:0]        stat_limit;
    } chan_cfg_t;

    // din[17:16] is the tap index, din[15:0] the Q1.14 coefficient.
    typedef struct packed {
        logic        valid;
        logic [24:0] din;
    } coef_wr_t;

    typedef struct packed {
        logic [7:0]  min;
        logic [7:0]  max;
        logic [31:0] count;
    } stat_t;

endpackage

//--- dac_channel_regs.sv
`timescale 1ns/1ps
`include "dac_channel_defines.svh"

module dac_channel_regs (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         penable,
    input  logic                         psel,
    input  logic [31:0]                  paddr,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,

    output dac_channel_pkg::chan_cfg_t   cfg,
    output dac_channel_pkg::coef_wr_t    coef_wr,
    input  dac_channel_pkg::stat_t       stat,

    output logic                         amp_en,
    output logic [2:0]                   led
);

    logic [11:0] addr;
    logic        wr_en;

    assign addr  = {paddr[11:2], 2'b00};
    assign wr_en = psel & penable & pwrite;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.gain       <= '0;
            cfg.offset     <= '0;
            cfg.mux        <= dac_channel_pkg::MUX_STREAM;
            cfg.raw        <= '0;
            cfg.att        <= `DAC_RESET_ATT;
            cfg.stat_en    <= 1'b1;
            cfg.stat_clear <= 1'b0;
            cfg.stat_limit <= '0;
            coef_wr.valid  <= 1'b0;
            coef_wr.din    <= '0;
            amp_en         <= 1'b0;
            led            <= 3'b000;
        end else begin
            // The coefficient strobe lasts a single cycle.
            coef_wr.valid <= 1'b0;

            if (wr_en) begin
                case (addr)
                    `DAC_REG_GAIN: cfg.gain <= pwdata[15:0];
                    `DAC_REG_OFFSET: cfg.offset <= pwdata[15:0];
                    `DAC_REG_FILTER_COEF: begin
                        coef_wr.din   <= pwdata[24:0];
                        coef_wr.valid <= 1'b1;
                    end
                    `DAC_REG_MUX: cfg.mux <= dac_channel_pkg::sample_mux_e'(pwdata[2:0]);
                    `DAC_REG_RAW: cfg.raw <= pwdata;
                    `DAC_REG_STAT_CFG: begin
                        cfg.stat_en    <= pwdata[0];
                        cfg.stat_clear <= pwdata[1];
                    end
                    `DAC_REG_STAT_LIMIT: cfg.stat_limit <= pwdata;
                    `DAC_REG_ATT: cfg.att <= pwdata[1:0];
                    `DAC_REG_AMP_EN: amp_en <= pwdata[0];
                    `DAC_REG_LED: led <= pwdata[2:0];
                    default: begin
                    end
                endcase
            end
        end
    end

    // Status read back. The min and max bytes are signed sample bytes.
    always_comb begin
        case (addr)
            `DAC_REG_STAT_MIN:   prdata = {{24{stat.min[7]}}, stat.min};
            `DAC_REG_STAT_MAX:   prdata = {{24{stat.max[7]}}, stat.max};
            `DAC_REG_STAT_COUNT: prdata = stat.count;
            default:             prdata = 32'h0;
        endcase
    end

endmodule

//--- dac_channel_stimulus.txt
# Columns: opcode, then hex operands. T name | W addr data | R addr expected_prdata
# S in_data expected_dac_data | M min max count | P amp_en led | X expected_raw_dac_data
T reset_values
R 018 0000007F
R 01C FFFFFF80
R 024 00000000
R 034 00000000
S 1234 0000
S 8000 0000
T stream_unity
W 000 00001000
W 004 0000FF38
W 028 00000000
S 0100 0038
S FF00 FE38
S 7FF0 7F28
S 8010 8000
T att_saturation
W 028 00000002
S 0400 00CE
S FC00 FECE
S 0065 FFE7
W 000 0000FFFF
W 004 00000000
W 028 00000000
S 4000 7FFF
S C000 8000
T fir_coefficients
W 000 00001000
S 0000 0000
S 0000 0000
S 0000 0000
W 008 00002000
W 008 0001F000
W 008 00024000
W 008 00030800
S 4000 2000
S 0000 F000
S 0000 4000
S 0000 0800
S 0000 0000
T statistics
W 008 00004000
W 008 00010000
W 008 00020000
W 008 00030000
W 020 00001000
W 014 00000003
W 014 00000001
S 1234 1234
S F800 F800
S 0FFF 0FFF
S 9ABC 9ABC
S 1001 1001
S F000 F000
M 9A 12 00000003
R 018 FFFFFF9A
W 014 00000003
M 7F 80 00000000
W 014 00000001
T raw_mode_pins
W 010 ABCD0300
W 000 00001800
W 004 00000010
W 028 00000001
W 00C 00000000
X 0248
W 02C 00000001
W 030 00000005
P 1 5

//--- dac_channel_top.sv
`timescale 1ns/1ps
`include "dac_channel_defines.svh"

module dac_channel_top (
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                penable,
    input  logic                                psel,
    input  logic [31:0]                         paddr,
    input  logic                                pwrite,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,

    input  logic                                in_req,
    input  logic [`DAC_SAMPLE_W-1:0]            in_data,
    output logic                                in_ack,

    output logic signed [`DAC_SAMPLE_W-1:0]     dac_data,
    output logic                                dac_valid,

    output logic                                amp_en,
    output logic [2:0]                          led
);

    dac_channel_pkg::chan_cfg_t      cfg;
    dac_channel_pkg::coef_wr_t       coef_wr;
    dac_channel_pkg::stat_t          stat;
    logic signed [`DAC_SAMPLE_W-1:0] smp_data;
    logic                            smp_valid;
    logic signed [`DAC_SAMPLE_W-1:0] go_data;
    logic                            go_valid;

    dac_channel_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .penable (penable),
        .psel    (psel),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .cfg     (cfg),
        .coef_wr (coef_wr),
        .stat    (stat),
        .amp_en  (amp_en),
        .led     (led)
    );

    dac_sample_source u_source (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .in_req    (in_req),
        .in_data   (in_data),
        .in_ack    (in_ack),
        .smp_data  (smp_data),
        .smp_valid (smp_valid)
    );

    dac_gain_offset u_gain (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .smp_data  (smp_data),
        .smp_valid (smp_valid),
        .go_data   (go_data),
        .go_valid  (go_valid)
    );

    dac_fir_filter u_fir (
        .clk       (clk),
        .reset     (reset),
        .coef_wr   (coef_wr),
        .go_data   (go_data),
        .go_valid  (go_valid),
        .dac_data  (dac_data),
        .dac_valid (dac_valid)
    );

    dac_stat_monitor u_stat (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .dac_data  (dac_data),
        .dac_valid (dac_valid),
        .stat      (stat)
    );

endmodule

//--- dac_fir_filter.sv
`timescale 1ns/1ps
`include "dac_channel_defines.svh"

module dac_fir_filter (
    input  logic                                clk,
    input  logic                                reset,
    input  dac_channel_pkg::coef_wr_t           coef_wr,
    input  logic signed [`DAC_SAMPLE_W-1:0]     go_data,
    input  logic                                go_valid,
    output logic signed [`DAC_SAMPLE_W-1:0]     dac_data,
    output logic                                dac_valid
);

    localparam logic signed [33:0] SAT_MAX = 34'sd32767;
    localparam logic signed [33:0] SAT_MIN = -34'sd32768;

    logic signed [15:0]              coef   [`DAC_TAPS];
    logic signed [`DAC_SAMPLE_W-1:0] hist   [`DAC_TAPS-1];
    logic signed [`DAC_SAMPLE_W-1:0] window [`DAC_TAPS];
    logic signed [33:0]              acc;
    logic signed [33:0]              scaled;
    logic signed [`DAC_SAMPLE_W-1:0] sat;

    // Tap 0 sees the incoming sample, the older taps come from the history.
    always_comb begin
        window[0] = go_data;
        for (int i = 1; i < `DAC_TAPS; i++) begin
            window[i] = hist[i-1];
        end
    end

    always_comb begin
        acc = '0;
        for (int i = 0; i < `DAC_TAPS; i++) begin
            acc = acc + coef[i] * window[i];
        end
        scaled = acc >>> `DAC_COEF_FRAC;

        if (scaled > SAT_MAX) begin
            sat = 16'sh7FFF;
        end else if (scaled < SAT_MIN) begin
            sat = 16'sh8000;
        end else begin
            sat = scaled[`DAC_SAMPLE_W-1:0];
        end
    end

    // The filter comes out of reset as a pass-through.
    always_ff @(posedge clk) begin
        if (reset) begin
            coef[0] <= `DAC_UNITY_COEF;
            for (int i = 1; i < `DAC_TAPS; i++) begin
                coef[i] <= '0;
            end
        end else if (coef_wr.valid) begin
            coef[coef_wr.din[17:16]] <= coef_wr.din[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DAC_TAPS - 1; i++) begin
                hist[i] <= '0;
            end
            dac_valid <= 1'b0;
        end else begin
            dac_valid <= go_valid;
            if (go_valid) begin
                for (int i = 0; i < `DAC_TAPS - 1; i++) begin
                    hist[i] <= window[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go_valid) begin
            dac_data <= sat;
        end
    end

endmodule

//--- dac_gain_offset.sv
`timescale 1ns/1ps
`include "dac_channel_defines.svh"

module dac_gain_offset (
    input  logic                                clk,
    input  logic                                reset,
    input  dac_channel_pkg::chan_cfg_t          cfg,
    input  logic signed [`DAC_SAMPLE_W-1:0]     smp_data,
    input  logic                                smp_valid,
    output logic signed [`DAC_SAMPLE_W-1:0]     go_data,
    output logic                                go_valid
);

    localparam logic signed [33:0] SAT_MAX = 34'sd32767;
    localparam logic signed [33:0] SAT_MIN = -34'sd32768;

    logic signed [32:0]              product;
    logic signed [33:0]              biased;
    logic signed [33:0]              shifted;
    logic signed [`DAC_SAMPLE_W-1:0] sat;

    always_comb begin
        // Gain is unsigned, so it gets a zero sign bit before the multiply.
        product = smp_data * $signed({1'b0, cfg.gain});
        biased  = (product >>> `DAC_GAIN_FRAC) + $signed(cfg.offset);
        shifted = biased >>> cfg.att;

        if (shifted > SAT_MAX) begin
            sat = 16'sh7FFF;
        end else if (shifted < SAT_MIN) begin
            sat = 16'sh8000;
        end else begin
            sat = shifted[`DAC_SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            go_valid <= 1'b0;
        end else begin
            go_valid <= smp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (smp_valid) begin
            go_data <= sat;
        end
    end

endmodule

//--- dac_sample_source.sv
`timescale 1ns/1ps
`include "dac_channel_defines.svh"

module dac_sample_source (
    input  logic                                clk,
    input  logic                                reset,
    input  dac_channel_pkg::chan_cfg_t          cfg,
    input  logic                                in_req,
    input  logic [`DAC_SAMPLE_W-1:0]            in_data,
    output logic                                in_ack,
    output logic signed [`DAC_SAMPLE_W-1:0]     smp_data,
    output logic                                smp_valid
);

    dac_channel_pkg::src_state_e     state;
    logic [`DAC_SAMPLE_W-1:0]        ramp;
    logic                            stream_mode;
    logic                            stream_take;
    logic [`DAC_SAMPLE_W-1:0]        sel_data;
    logic                            sel_valid;

    assign stream_mode = (cfg.mux == dac_channel_pkg::MUX_STREAM);
    assign stream_take = (state == dac_channel_pkg::SRC_IDLE) && stream_mode && in_req;

    // Handshake FSM. in_ack rises on the capture edge and falls once in_req is seen low.
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= dac_channel_pkg::SRC_IDLE;
            in_ack <= 1'b0;
        end else begin
            case (state)
                dac_channel_pkg::SRC_IDLE: begin
                    if (stream_take) begin
                        in_ack <= 1'b1;
                        state  <= dac_channel_pkg::SRC_ACK;
                    end
                end
                dac_channel_pkg::SRC_ACK: begin
                    if (!in_req || !stream_mode) begin
                        in_ack <= 1'b0;
                        state  <= dac_channel_pkg::SRC_WAIT_LOW;
                    end
                end
                dac_channel_pkg::SRC_WAIT_LOW: state <= dac_channel_pkg::SRC_IDLE;
                default: begin
                    in_ack <= 1'b0;
                    state  <= dac_channel_pkg::SRC_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        case (cfg.mux)
            dac_channel_pkg::MUX_RAW: begin
                sel_data  = cfg.raw[`DAC_SAMPLE_W-1:0];
                sel_valid = 1'b1;
            end
            dac_channel_pkg::MUX_STREAM: begin
                sel_data  = in_data;
                sel_valid = stream_take;
            end
            dac_channel_pkg::MUX_RAMP: begin
                sel_data  = ramp;
                sel_valid = 1'b1;
            end
            default: begin
                sel_data  = '0;
                sel_valid = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            smp_valid <= 1'b0;
            ramp      <= '0;
        end else begin
            smp_valid <= sel_valid;
            if (cfg.mux == dac_channel_pkg::MUX_RAMP) begin
                ramp <= ramp + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            smp_data <= sel_data;
        end
    end

endmodule

//--- dac_stat_monitor.sv
`timescale 1ns/1ps
`include "dac_channel_defines.svh"

module dac_stat_monitor (
    input  logic                                clk,
    input  logic                                reset,
    input  dac_channel_pkg::chan_cfg_t          cfg,
    input  logic signed [`DAC_SAMPLE_W-1:0]     dac_data,
    input  logic                                dac_valid,
    output dac_channel_pkg::stat_t              stat
);

    logic signed [7:0]        top_byte;
    logic [`DAC_SAMPLE_W:0]   mag;
    logic                     over_limit;

    assign top_byte = dac_data[`DAC_SAMPLE_W-1:`DAC_SAMPLE_W-8];

    // One extra bit keeps the magnitude of the most negative sample.
    always_comb begin
        if (dac_data[`DAC_SAMPLE_W-1]) begin
            mag = '0 - {1'b1, dac_data};
        end else begin
            mag = {1'b0, dac_data};
        end
        over_limit = {15'd0, mag} > cfg.stat_limit;
    end

    always_ff @(posedge clk) begin
        if (reset || cfg.stat_clear) begin
            stat.min   <= 8'h7F;
            stat.max   <= 8'h80;
            stat.count <= '0;
        end else if (dac_valid && cfg.stat_en) begin
            if (top_byte < $signed(stat.min)) begin
                stat.min <= top_byte;
            end
            if (top_byte > $signed(stat.max)) begin
                stat.max <= top_byte;
            end
            if (over_limit) begin
                stat.count <= stat.count + 1'b1;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DAC channel testbench with Verilator, then scan the log.
rm -rf obj_dir sim.log

verilator --binary --timing -f dac_channel.f --top-module tb_dac_channel -o tb_dac_channel \
    && ./obj_dir/tb_dac_channel > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log \
    && { echo "Testbench reported a failure"; exit 1; } \
    || { echo "No failure found in sim.log"; exit 0; }

//--- tb_dac_channel.sv
`timescale 1ns/1ps
`include "dac_channel_defines.svh"

module tb_dac_channel;

    logic                                clk;
    logic                                reset;
    logic                                penable;
    logic                                psel;
    logic [31:0]                         paddr;
    logic                                pwrite;
    logic [31:0]                         pwdata;
    logic [31:0]                         prdata;
    logic                                in_req;
    logic [`DAC_SAMPLE_W-1:0]            in_data;
    logic                                in_ack;
    logic signed [`DAC_SAMPLE_W-1:0]     dac_data;
    logic                                dac_valid;
    logic                                amp_en;
    logic [2:0]                          led;

    int                                  errors;
    int                                  timeouts;
    logic [8*24-1:0]                     test_name;

    dac_channel_top DUT (
        .clk       (clk),
        .reset     (reset),
        .penable   (penable),
        .psel      (psel),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .in_req    (in_req),
        .in_data   (in_data),
        .in_ack    (in_ack),
        .dac_data  (dac_data),
        .dac_valid (dac_valid),
        .amp_en    (amp_en),
        .led       (led)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_sample(input string what, input logic [15:0] exp,
                                input logic [15:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_stat(input dac_channel_pkg::stat_t exp,
                              input dac_channel_pkg::stat_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0s stat: expected min/max/count %h/%h/%0d, actual %h/%h/%0d",
                     test_name, exp.min, exp.max, exp.count, act.min, act.max, act.count);
        end
    endtask

    // Setup phase, then access phase; the register block writes on the access edge.
    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_stats(output dac_channel_pkg::stat_t st);
        logic [31:0] w;
        apb_read({20'h0, `DAC_REG_STAT_MIN}, w);
        st.min = w[7:0];
        apb_read({20'h0, `DAC_REG_STAT_MAX}, w);
        st.max = w[7:0];
        apb_read({20'h0, `DAC_REG_STAT_COUNT}, w);
        st.count = w;
    endtask

    // One four-phase transfer. The in_ack edge counts as the first of three stages.
    task automatic stream_sample(input logic [15:0] data, input logic [15:0] exp);
        int          n;
        logic [31:0] lat;
        @(posedge clk);
        in_data <= data;
        in_req  <= 1'b1;
        @(negedge clk);
        n = 0;
        while (!in_ack && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!in_ack) begin
            timeouts++;
            $display("Timeout in %0s: in_ack did not rise for sample %h", test_name, data);
            @(posedge clk);
            in_req <= 1'b0;
        end else begin
            lat = 32'd1;
            n = 0;
            while (!dac_valid && n < 100) begin
                @(posedge clk);
                in_req <= 1'b0;
                @(negedge clk);
                lat = lat + 32'd1;
                n++;
            end
            if (!dac_valid) begin
                timeouts++;
                $display("Timeout in %0s: dac_valid did not rise for sample %h", test_name, data);
            end else begin
                check_word("dac_valid latency", 32'd3, lat);
                check_sample("dac_data", exp, dac_data);
            end
            n = 0;
            while (in_ack && n < 100) begin
                @(negedge clk);
                n++;
            end
            if (in_ack) begin
                timeouts++;
                $display("Timeout in %0s: in_ack did not fall after in_req dropped", test_name);
            end
        end
    endtask

    // Raw mode gives a sample every cycle, so dac_valid must stay high.
    task automatic raw_steady_check(input logic [15:0] exp);
        int n;
        @(posedge clk);
        in_req <= 1'b1;
        @(negedge clk);
        n = 0;
        while (!dac_valid && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!dac_valid) begin
            timeouts++;
            $display("Timeout in %0s: dac_valid did not rise in raw mode", test_name);
        end else begin
            repeat (8) begin
                check_sample("dac_data", exp, dac_data);
                check_word("dac_valid", 32'd1, {31'd0, dac_valid});
                check_word("in_ack", 32'd0, {31'd0, in_ack});
                @(negedge clk);
            end
        end
        @(posedge clk);
        in_req <= 1'b0;
    endtask

    initial begin
        int                     fd;
        int                     code;
        logic                   done;
        logic [7:0]             op;
        logic [8*160-1:0]       line;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            c;
        logic [31:0]            w;
        dac_channel_pkg::stat_t exp_st;
        dac_channel_pkg::stat_t act_st;

        errors    = 0;
        timeouts  = 0;
        test_name = "startup";
        reset     = 1'b1;
        penable   = 1'b0;
        psel      = 1'b0;
        paddr     = 32'h0;
        pwrite    = 1'b0;
        pwdata    = 32'h0;
        in_req    = 1'b0;
        in_data   = '0;
        done      = 1'b0;

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("dac_channel_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file dac_channel_stimulus.txt");
            done = 1'b1;
        end

        while (!done) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                code = $fgets(line, fd);
            end else if (op == "T") begin
                code = $fscanf(fd, "%s", test_name);
                $display("Running %0s", test_name);
            end else if (op == "W") begin
                code = $fscanf(fd, "%h %h", a, b);
                apb_write(a, b);
            end else if (op == "R") begin
                code = $fscanf(fd, "%h %h", a, b);
                apb_read(a, w);
                check_word("prdata", b, w);
            end else if (op == "S") begin
                code = $fscanf(fd, "%h %h", a, b);
                stream_sample(a[15:0], b[15:0]);
            end else if (op == "M") begin
                code = $fscanf(fd, "%h %h %h", a, b, c);
                exp_st.min   = a[7:0];
                exp_st.max   = b[7:0];
                exp_st.count = c;
                read_stats(act_st);
                check_stat(exp_st, act_st);
            end else if (op == "P") begin
                code = $fscanf(fd, "%h %h", a, b);
                @(negedge clk);
                check_word("amp_en", a, {31'd0, amp_en});
                check_word("led", b, {29'd0, led});
            end else if (op == "X") begin
                code = $fscanf(fd, "%h", a);
                raw_steady_check(a[15:0]);
            end else begin
                errors++;
                $display("Unknown opcode in the stimulus file, reading stops here");
                done = 1'b1;
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
